/* build.f */
+incdir+testbench
source/i2c_bus_pkg.sv
source/target_map_pkg.sv
source/i2c_bus_framer.sv
source/target_channel.sv
source/response_merge.sv
source/i2c_target_hub.sv
testbench/tb_i2c_target_hub.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_i2c_target_hub \
    -f build.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_i2c_target_hub >> sim.log 2>&1 \
    || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

/* source/i2c_bus_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_bus_framer (
    input  wire logic                       vif,
    input  wire logic                       sda,
    input  wire logic                       scl,
    input  wire logic                       sdat,
    input  wire target_map_pkg::chan_resp_t resp,
    output i2c_bus_pkg::bus_event_t         bus_event,
    output logic                            sdat_low
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_ACK,
        ST_WRITE,
        ST_READ,
        ST_IGNORE
    } state_t;

    state_t                  state;
    logic [1:0]              scl_sync;
    logic [1:0]              sdat_sync;
    logic                    scl_prev;
    logic                    sdat_prev;
    i2c_bus_pkg::bit_count_t bit_cnt;
    i2c_bus_pkg::i2c_byte_t  shift;
    i2c_bus_pkg::i2c_byte_t  shift_in;
    logic                    rw_q;

    logic scl_s;
    logic sdat_s;
    logic scl_rise;
    logic scl_fall;
    logic start_seen;
    logic stop_seen;

    assign scl_s      = scl_sync[1];
    assign sdat_s     = sdat_sync[1];
    assign scl_rise   = scl_s && !scl_prev;
    assign scl_fall   = !scl_s && scl_prev;
    assign start_seen = scl_s && scl_prev && !sdat_s && sdat_prev;
    assign stop_seen  = scl_s && scl_prev && sdat_s && !sdat_prev;
    assign shift_in   = {shift[6:0], sdat_s};  // MSB first

    // Idle bus reads high, so no false edge after reset
    always_ff @(posedge vif or negedge sda) begin
        if (!sda) begin
            scl_sync  <= 2'b11;
            sdat_sync <= 2'b11;
            scl_prev  <= 1'b1;
            sdat_prev <= 1'b1;
        end else begin
            scl_sync  <= {scl_sync[0], scl};
            sdat_sync <= {sdat_sync[0], sdat};
            scl_prev  <= scl_s;
            sdat_prev <= sdat_s;
        end
    end

    always_ff @(posedge vif or negedge sda) begin
        if (!sda) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            shift     <= '0;
            rw_q      <= 1'b0;
            sdat_low  <= 1'b0;
            bus_event <= '0;
        end else begin
            bus_event.start      <= 1'b0;
            bus_event.stop       <= 1'b0;
            bus_event.addr_valid <= 1'b0;
            bus_event.wr_valid   <= 1'b0;
            bus_event.rd_done    <= 1'b0;

            if (start_seen) begin
                state           <= ST_ADDR;
                bit_cnt         <= '0;
                sdat_low        <= 1'b0;
                bus_event.start <= 1'b1;
            end else if (stop_seen) begin
                state          <= ST_IDLE;
                sdat_low       <= 1'b0;
                bus_event.stop <= 1'b1;
            end else begin
                case (state)
                    ST_ADDR, ST_WRITE: begin
                        if (scl_fall) begin
                            sdat_low <= 1'b0;  // Drop the previous ack
                        end
                        if (scl_rise) begin
                            shift   <= shift_in;
                            bit_cnt <= bit_cnt + 4'd1;
                            if (bit_cnt == 4'd7) begin
                                bus_event.data <= shift_in;
                                state          <= ST_ACK;
                                if (state == ST_ADDR) begin
                                    bus_event.addr_valid <= 1'b1;
                                    bus_event.rw         <= sdat_s;
                                    rw_q                 <= sdat_s;
                                end else begin
                                    bus_event.wr_valid <= 1'b1;
                                end
                            end
                        end
                    end
                    ST_ACK: begin
                        // Pull low across the ninth clock
                        if (scl_fall) begin
                            sdat_low <= resp.selected && resp.ack;
                        end
                        if (scl_rise) begin
                            bit_cnt <= '0;
                            if (!sdat_low) begin
                                state <= ST_IGNORE;  // Nobody answered
                            end else if (rw_q) begin
                                state <= ST_READ;
                            end else begin
                                state <= ST_WRITE;
                            end
                        end
                    end
                    ST_READ: begin
                        if (scl_fall) begin
                            if (bit_cnt == 4'd8) begin
                                sdat_low <= 1'b0;  // Controller owns the ack bit
                            end else if (bit_cnt == 4'd0) begin
                                sdat_low <= !resp.rd_data[7];
                                shift    <= {resp.rd_data[6:0], 1'b0};
                            end else begin
                                sdat_low <= !shift[7];
                                shift    <= {shift[6:0], 1'b0};
                            end
                        end
                        if (scl_rise) begin
                            if (bit_cnt == 4'd8) begin
                                bit_cnt            <= '0;
                                bus_event.rd_done  <= 1'b1;
                                bus_event.ctrl_ack <= !sdat_s;
                                bus_event.data     <= resp.rd_data;
                                if (sdat_s) begin
                                    state <= ST_IGNORE;  // Not acknowledged
                                end
                            end else begin
                                bit_cnt <= bit_cnt + 4'd1;
                            end
                        end
                    end
                    ST_IGNORE: begin
                        sdat_low <= 1'b0;
                    end
                    default: begin
                        sdat_low <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/i2c_bus_pkg.sv */
`default_nettype none

package i2c_bus_pkg;

    typedef logic [6:0] i2c_addr_t;
    typedef logic [7:0] i2c_byte_t;

    // Position inside a nine bit frame, 0 to 8
    typedef logic [3:0] bit_count_t;

    // Broadcast from the framer to every channel
    typedef struct packed {
        logic      start;       // Start or repeated start
        logic      stop;
        logic      addr_valid;  // Address byte complete
        logic      wr_valid;    // Written data byte complete
        logic      rd_done;     // Read byte plus controller ack complete
        logic      rw;          // Direction bit of the last address
        i2c_byte_t data;
        logic      ctrl_ack;    // High when the controller acknowledged
    } bus_event_t;

endpackage

`default_nettype wire

/* source/i2c_target_hub.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_target_hub #(
    parameter int                     N_CHANNELS = 4,
    parameter i2c_bus_pkg::i2c_addr_t BASE_ADDR  = 7'h48,
    parameter int                     REG_COUNT  = 4
) (
    input  wire logic vif,
    input  wire logic sda,
    input  wire logic scl,
    input  wire logic sdat,
    output logic      sdat_low
);

    i2c_bus_pkg::bus_event_t    bus_event;
    target_map_pkg::chan_resp_t chan_resp [N_CHANNELS];
    target_map_pkg::chan_resp_t resp;

    i2c_bus_framer u_i2c_bus_framer (
        .vif       (vif),
        .sda       (sda),
        .scl       (scl),
        .sdat      (sdat),
        .resp      (resp),
        .bus_event (bus_event),
        .sdat_low  (sdat_low)
    );

    // Channel i answers BASE_ADDR + i
    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_chan
        target_channel #(
            .CHAN_ADDR (i2c_bus_pkg::i2c_addr_t'(BASE_ADDR + i)),
            .REG_COUNT (REG_COUNT)
        ) u_target_channel (
            .vif       (vif),
            .sda       (sda),
            .bus_event (bus_event),
            .resp      (chan_resp[i])
        );
    end

    response_merge #(
        .N_CHANNELS (N_CHANNELS)
    ) u_response_merge (
        .vif       (vif),
        .sda       (sda),
        .chan_resp (chan_resp),
        .resp      (resp)
    );

endmodule

`default_nettype wire

/* source/response_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module response_merge #(
    parameter int N_CHANNELS = 4
) (
    input  wire logic                       vif,
    input  wire logic                       sda,
    input  wire target_map_pkg::chan_resp_t chan_resp [N_CHANNELS],
    output target_map_pkg::chan_resp_t      resp
);

    target_map_pkg::chan_resp_t picked;

    // Addresses are distinct, so a plain OR of the selected entries is enough
    always_comb begin
        picked = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (chan_resp[i].selected) begin
                picked = picked | chan_resp[i];
            end
        end
    end

    always_ff @(posedge vif or negedge sda) begin
        if (!sda) begin
            resp <= '0;
        end else begin
            resp <= picked;  // All zero when nobody is selected
        end
    end

endmodule

`default_nettype wire

/* source/target_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module target_channel #(
    parameter i2c_bus_pkg::i2c_addr_t CHAN_ADDR = 7'h48,
    parameter int                     REG_COUNT = 4
) (
    input  wire logic                     vif,
    input  wire logic                     sda,
    input  wire i2c_bus_pkg::bus_event_t  bus_event,
    output target_map_pkg::chan_resp_t    resp
);

    localparam int IDX_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;
    localparam target_map_pkg::reg_idx_t PTR_MASK =
        target_map_pkg::reg_idx_t'(REG_COUNT - 1);

    i2c_bus_pkg::i2c_byte_t   regs [REG_COUNT];
    target_map_pkg::reg_idx_t ptr;
    target_map_pkg::reg_idx_t ptr_next;
    target_map_pkg::reg_idx_t ptr_load;
    logic                     selected;
    logic                     ptr_pending;  // Next write byte is the pointer
    logic                     addr_match;

    assign addr_match = (bus_event.data[7:1] == CHAN_ADDR);
    assign ptr_next   = (ptr + target_map_pkg::reg_idx_t'(1)) & PTR_MASK;
    assign ptr_load   = target_map_pkg::reg_idx_t'(bus_event.data) & PTR_MASK;

    always_ff @(posedge vif or negedge sda) begin
        if (!sda) begin
            selected    <= 1'b0;
            ptr_pending <= 1'b0;
            ptr         <= '0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (bus_event.start || bus_event.stop) begin
                selected    <= 1'b0;
                ptr_pending <= 1'b0;
            end else if (bus_event.addr_valid) begin
                selected    <= addr_match;
                ptr_pending <= addr_match && !bus_event.rw;
            end else if (selected) begin
                if (bus_event.wr_valid) begin
                    if (ptr_pending) begin
                        ptr         <= ptr_load;
                        ptr_pending <= 1'b0;
                    end else begin
                        regs[ptr[IDX_W-1:0]] <= bus_event.data;
                        ptr                  <= ptr_next;
                    end
                end
                // Advance only when the controller wants another byte
                if (bus_event.rd_done && bus_event.ctrl_ack) begin
                    ptr <= ptr_next;
                end
            end
        end
    end

    always_comb begin
        resp.selected = selected;
        resp.ack      = selected;  // Every byte of a selected transfer
        resp.rd_data  = regs[ptr[IDX_W-1:0]];
    end

endmodule

`default_nettype wire

/* source/target_map_pkg.sv */
`default_nettype none

package target_map_pkg;

    // Byte wide pointer that each channel masks down to its REG_COUNT
    localparam int MAX_REG_COUNT = 256;

    typedef logic [$clog2(MAX_REG_COUNT)-1:0] reg_idx_t;

    typedef struct packed {
        logic                   selected;
        logic                   ack;      // Acknowledge the current byte
        i2c_bus_pkg::i2c_byte_t rd_data;  // Register at the pointer
    } chan_resp_t;

endpackage

`default_nettype wire

/* testbench/i2c_ctrl_model.svh */
`ifndef I2C_CTRL_MODEL_SVH
`define I2C_CTRL_MODEL_SVH

logic [31:0] lfsr_state  = 32'h1c790384;
int          err_count   = 0;
int          check_count = 0;

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v          = {v[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'ha300_0000 : 32'h0);
    end
    return v;
endfunction

task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
    check_count++;
    if (expected !== actual) begin
        err_count++;
        $display("MISMATCH %s expected %02h actual %02h", name, expected, actual);
    end
endtask

// Wait n cycles and set both controller pins
task automatic step(input int n, input logic s, input logic d);
    repeat (n) @(posedge vif);
    #1;
    scl       = s;
    ctrl_sdat = d;
endtask

task automatic clock_bit(input logic b, output logic seen);
    step(PHASE / 2, 1'b0, b);  // Data changes mid low phase
    step(PHASE / 2, 1'b1, b);
    step(PHASE / 2, 1'b1, b);
    seen = sdat_line;
    step(PHASE / 2, 1'b0, b);
endtask

// Also serves as repeated start
task automatic bus_start();
    step(PHASE / 2, 1'b0, 1'b1);
    step(PHASE / 2, 1'b1, 1'b1);
    step(PHASE, 1'b1, 1'b0);
    step(PHASE, 1'b0, 1'b0);
endtask

task automatic bus_stop();
    step(PHASE / 2, 1'b0, 1'b0);
    step(PHASE / 2, 1'b1, 1'b0);
    step(PHASE, 1'b1, 1'b1);
    step(PHASE, 1'b1, 1'b1);
endtask

task automatic write_byte(input logic [7:0] d, output logic ack);
    logic seen;
    for (int i = 7; i >= 0; i--) begin
        clock_bit(d[i], seen);
    end
    clock_bit(1'b1, seen);  // Released for the target ack
    ack = !seen;
endtask

task automatic read_byte(input logic ack, output logic [7:0] d);
    logic seen;
    for (int i = 7; i >= 0; i--) begin
        clock_bit(1'b1, seen);
        d[i] = seen;
    end
    clock_bit(!ack, seen);
endtask

`endif

/* testbench/tb_i2c_target_hub.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_target_hub;

    localparam int         N_CH      = 4;
    localparam int         REG_N     = 4;
    localparam logic [6:0] BASE      = 7'h48;
    localparam int         PHASE     = 20;
    localparam int         BUS_BYTES = 108;  // All bytes of the six tests
    localparam int         LIMIT     = BUS_BYTES * 9 * 40 + 10000;

    typedef enum {K_ADDR, K_WR, K_RD} kind_t;

    logic       vif;
    logic       sda;
    logic       scl;
    logic       ctrl_sdat;
    logic       sdat_line;
    logic       sdat_low;
    logic [7:0] exp_q [$];
    logic [7:0] obs_q [$];
    logic [7:0] shadow [N_CH][REG_N];
    int         shadow_ptr [N_CH];
    int         cur_chan;
    logic       ptr_byte_next;  // Next written byte is the pointer
    string      cur_test;
    int         test_err_base;
    int         n_tests;
    int         pull_cycles = 0;
    int         pull_snap;
    int         ch;

    `include "i2c_ctrl_model.svh"

    assign sdat_line = ctrl_sdat & !sdat_low;  // Wired AND

    i2c_target_hub u_i2c_target_hub (
        .vif      (vif),
        .sda      (sda),
        .scl      (scl),
        .sdat     (sdat_line),
        .sdat_low (sdat_low)
    );

    always #5 vif = ~vif;

    always @(posedge vif) begin
        if (sdat_low) begin
            pull_cycles <= pull_cycles + 1;
        end
    end

    // Shadow register map fed one bus byte at a time
    function automatic logic [7:0] predict(input kind_t kind, input logic [7:0] value);
        int         idx;
        logic [7:0] result;
        result = 8'h00;
        if (kind == K_ADDR) begin
            idx           = int'(value[7:1]) - int'(BASE);
            cur_chan      = (idx >= 0 && idx < N_CH) ? idx : -1;
            ptr_byte_next = (cur_chan >= 0) && !value[0];
            result        = (cur_chan >= 0) ? 8'h01 : 8'h00;
        end else if (cur_chan >= 0 && kind == K_WR) begin
            result = 8'h01;
            if (ptr_byte_next) begin
                shadow_ptr[cur_chan] = int'(value) % REG_N;
                ptr_byte_next        = 1'b0;
            end else begin
                shadow[cur_chan][shadow_ptr[cur_chan]] = value;
                shadow_ptr[cur_chan] = (shadow_ptr[cur_chan] + 1) % REG_N;
            end
        end else if (cur_chan >= 0 && kind == K_RD) begin
            result = shadow[cur_chan][shadow_ptr[cur_chan]];
            if (value[0]) begin
                shadow_ptr[cur_chan] = (shadow_ptr[cur_chan] + 1) % REG_N;
            end
        end
        return result;
    endfunction

    task automatic put_byte(input kind_t kind, input logic [7:0] d);
        logic ack;
        exp_q.push_back(predict(kind, d));
        write_byte(d, ack);
        obs_q.push_back({7'd0, ack});
    endtask

    task automatic fetch_data(input logic ack);
        logic [7:0] d;
        exp_q.push_back(predict(K_RD, {7'd0, ack}));
        read_byte(ack, d);
        obs_q.push_back(d);
    endtask

    // Pointer write, n_wr data bytes, then optionally a restart and n_rd reads
    task automatic transfer(input int c, input logic [7:0] p, input int n_wr, input int n_rd);
        logic [6:0] a;
        a = 7'(int'(BASE) + c);
        bus_start();
        put_byte(K_ADDR, {a, 1'b0});
        put_byte(K_WR, p);
        for (int i = 0; i < n_wr; i++) begin
            put_byte(K_WR, 8'(rand_bits(8)));
        end
        if (n_rd > 0) begin
            bus_start();
            put_byte(K_ADDR, {a, 1'b1});
            for (int i = 0; i < n_rd; i++) begin
                fetch_data(i < n_rd - 1);  // Last byte not acknowledged
            end
        end
        pull_snap = pull_cycles;
        bus_stop();
    endtask

    task automatic end_test();
        while (obs_q.size() != 0 || exp_q.size() != 0) begin
            @(posedge vif);
        end
        n_tests++;
        $display("%s finished, %0d errors", cur_test, err_count - test_err_base);
        test_err_base = err_count;
    endtask

    initial begin : compare
        forever begin
            @(posedge vif);
            while (obs_q.size() > 0 && exp_q.size() > 0) begin
                check(cur_test, exp_q.pop_front(), obs_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT) @(posedge vif);
        $display("Run timed out before the tests completed");
        $display("Something failed");
        $finish;
    end

    initial begin : main
        vif           = 1'b0;
        sda           = 1'b0;
        scl           = 1'b1;
        ctrl_sdat     = 1'b1;
        cur_chan      = -1;
        ptr_byte_next = 1'b0;
        n_tests       = 0;
        test_err_base = 0;
        for (int c = 0; c < N_CH; c++) begin
            shadow_ptr[c] = 0;
            for (int r = 0; r < REG_N; r++) begin
                shadow[c][r] = 8'h00;
            end
        end
        repeat (16) @(posedge vif);
        #1;
        sda = 1'b1;
        step(PHASE, 1'b1, 1'b1);

        cur_test = "reset_state";
        check(cur_test, 8'h00, {7'd0, sdat_low});  // Idle bus
        for (int c = 0; c < N_CH; c++) begin
            transfer(c, 8'h00, 0, REG_N);
        end
        end_test();

        cur_test = "address_decode";
        for (int i = -2; i < N_CH + 2; i++) begin
            bus_start();
            put_byte(K_ADDR, {7'(int'(BASE) + i), 1'b0});
            pull_snap = pull_cycles;
            put_byte(K_WR, 8'(rand_bits(8)));
            bus_stop();
            if (cur_chan < 0) begin
                check(cur_test, 8'h00, {7'd0, pull_cycles != pull_snap});  // Hub stays silent
            end
        end
        end_test();

        cur_test = "write_readback";
        ch = int'(rand_bits(2));
        pull_snap = int'(rand_bits(8));
        transfer(ch, 8'(pull_snap), 3, 0);
        transfer(ch, 8'(pull_snap), 0, 3);
        end_test();

        cur_test = "pointer_wrap";
        ch = int'(rand_bits(2));
        transfer(ch, 8'd2, REG_N + 2, 0);
        transfer(ch, 8'd0, 0, REG_N);
        end_test();

        cur_test = "channel_isolation";
        transfer(1, 8'd0, REG_N, 0);
        for (int c = 0; c < N_CH; c++) begin
            if (c != 1) begin
                transfer(c, 8'd0, 0, REG_N);
            end
        end
        end_test();

        cur_test = "read_termination";
        ch = int'(rand_bits(2));
        transfer(ch, 8'(rand_bits(8)), 0, 1);
        check(cur_test, 8'h00, {7'd0, pull_cycles != pull_snap});  // Released after the nack
        transfer(ch, 8'(rand_bits(8)), 0, REG_N);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", n_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
